// ==== filelist.f ====
common/texcache_cfg_pkg.sv
common/texcache_types_pkg.sv
texcache/texcache_qpram.sv
texcache/texcache_tagmem.sv
texcache/texcache_fetch.sv
texcache/texcache_datamem.sv
design/texcache_top.sv
testbench/texcache_tb.sv

// ==== Bender.yml ====
package:
  name: texcache

sources:
  # Packages first, then the blocks and the top level.
  - common/texcache_cfg_pkg.sv
  - common/texcache_types_pkg.sv
  - texcache/texcache_qpram.sv
  - texcache/texcache_tagmem.sv
  - texcache/texcache_fetch.sv
  - texcache/texcache_datamem.sv
  - design/texcache_top.sv
  - target: simulation
    files:
      - testbench/texcache_tb.sv

// ==== testbench/texcache_tb.sv ====
// Random quad fragments with a 256-texel row pitch; memory data is a fixed hash of each texel address.
`timescale 1ns/1ps

module texcache_tb;
	import texcache_cfg_pkg::*;
	import texcache_types_pkg::*;

	localparam int NUM_FRAGS = 400;
	localparam int ROW_PITCH = 256; // Rows land on different line indices.
	localparam int TIMEOUT_CYCLES = NUM_FRAGS * 60;

	logic sys_clk, sys_rst;
	logic frag_stb, frag_ack;
	texel_adr_u tadr_a, tadr_b, tadr_c, tadr_d;
	logic [DST_ADR_W-1:0] dadr, pipe_dadr;
	logic [FRAC_W-1:0] x_frac, y_frac, pipe_x_frac, pipe_y_frac;
	logic pipe_stb, pipe_ack;
	texel_t color_a, color_b, color_c, color_d;
	logic mem_stb, mem_ack;
	line_adr_t mem_adr;
	line_t mem_dat;
	logic busy;

	logic [31:0] seed;
	logic [99:0] exp_frag_q [$]; // Dadr, fractions, colours a to d.
	line_adr_t exp_line_q [$]; // Misses in request order.
	logic [99:0] exp_word, held_out;
	logic [2**INDEX_W-1:0] mdl_valid;
	logic [TAG_W-1:0] mdl_tag [2**INDEX_W];
	int cycle, sent, received, mem_reads, exp_reads, mem_wait;
	logic running, hold_q;

	texcache_top uut (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.frag_stb_i(frag_stb), .frag_ack_o(frag_ack),
		.frag_tadr_a_i(tadr_a), .frag_tadr_b_i(tadr_b),
		.frag_tadr_c_i(tadr_c), .frag_tadr_d_i(tadr_d),
		.frag_dadr_i(dadr), .frag_x_frac_i(x_frac), .frag_y_frac_i(y_frac),
		.pipe_stb_o(pipe_stb), .pipe_ack_i(pipe_ack), .pipe_dadr_o(pipe_dadr),
		.pipe_color_a_o(color_a), .pipe_color_b_o(color_b),
		.pipe_color_c_o(color_c), .pipe_color_d_o(color_d),
		.pipe_x_frac_o(pipe_x_frac), .pipe_y_frac_o(pipe_y_frac),
		.mem_stb_o(mem_stb), .mem_ack_i(mem_ack), .mem_adr_o(mem_adr), .mem_dat_i(mem_dat),
		.busy_o(busy)
	);

	initial sys_clk = 1'b0;
	always #2 sys_clk = ~sys_clk;

	// ########################################################################
	// Helpers
	// ########################################################################

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Colour stored at a texel address.
	function automatic texel_t texel_mix(input logic [TEX_ADR_W-1:0] adr);
		logic [31:0] h;
		h = {8'h00, adr} * 32'h9e3779b1;
		return h[31:16] ^ adr[15:0];
	endfunction

	function automatic line_t line_mix(input line_adr_t ladr);
		line_t ln;
		for (int k = 0; k < LINE_TEXELS; k++)
			ln[k] = texel_mix({ladr, OFFSET_W'(k)});
		return ln;
	endfunction

	task automatic abort_run(input string reason);
		$display("Error at %0t ns: %s", $time, reason);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// Direct-mapped tag copy; a miss queues the line read.
	task automatic model_lookup(input logic [TEX_ADR_W-1:0] raw);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0] tag;
		idx = raw[INDEX_W+OFFSET_W-1:OFFSET_W];
		tag = raw[TEX_ADR_W-1:INDEX_W+OFFSET_W];
		if (!mdl_valid[idx] || mdl_tag[idx] != tag) begin
			exp_line_q.push_back({tag, idx});
			mdl_valid[idx] = 1'b1;
			mdl_tag[idx] = tag;
			exp_reads++;
		end
	endtask

	task automatic record_fragment();
		exp_frag_q.push_back({dadr, x_frac, y_frac, texel_mix(tadr_a.raw),
			texel_mix(tadr_b.raw), texel_mix(tadr_c.raw), texel_mix(tadr_d.raw)});
		model_lookup(tadr_a.raw); // Order a to d, as the FIFO fills.
		model_lookup(tadr_b.raw);
		model_lookup(tadr_c.raw);
		model_lookup(tadr_d.raw);
	endtask

	task automatic drive_fragment();
		logic [TEX_ADR_W-1:0] base;
		seed = xorshift(seed);
		base = TEX_ADR_W'(seed[12:0]); // Small region, many hits.
		if (seed[27:26] == 2'b11)
			base = base + 24'h070000; // Other tag, same indices.
		tadr_a.raw <= base;
		tadr_b.raw <= base + 1;
		tadr_c.raw <= base + ROW_PITCH;
		tadr_d.raw <= base + ROW_PITCH + 1;
		seed = xorshift(seed);
		dadr <= seed[DST_ADR_W-1:0];
		x_frac <= seed[29:24];
		seed = xorshift(seed);
		y_frac <= seed[FRAC_W-1:0];
		frag_stb <= 1'b1;
	endtask

	// ########################################################################
	// Per-cycle stimulus and checks
	// ########################################################################

	always @(posedge sys_clk) begin
		if (running) begin
			cycle++;
			if (cycle > TIMEOUT_CYCLES) begin
				abort_run("timeout, the fragments did not all come out");
			end else begin
				if (frag_stb && frag_ack) begin
					record_fragment();
					sent++;
					frag_stb <= 1'b0;
				end
				seed = xorshift(seed);
				if ((!frag_stb || frag_ack) && sent < NUM_FRAGS && seed[1:0] != 2'b00)
					drive_fragment();

				if (hold_q) begin
					compare("pipe_stb_o", pipe_stb, 1'b1); // No drop while stalled.
					compare("pipe outputs", {pipe_dadr, pipe_x_frac, pipe_y_frac,
						color_a, color_b, color_c, color_d}, held_out);
				end
				if (pipe_stb && pipe_ack) begin
					if (exp_frag_q.size() == 0) begin
						abort_run("output transfer with no fragment outstanding");
					end else begin
						exp_word = exp_frag_q.pop_front();
						compare("pipe_dadr_o", pipe_dadr, exp_word[99:76]);
						compare("pipe_x_frac_o", pipe_x_frac, exp_word[75:70]);
						compare("pipe_y_frac_o", pipe_y_frac, exp_word[69:64]);
						compare("pipe_color_a_o", color_a, exp_word[63:48]);
						compare("pipe_color_b_o", color_b, exp_word[47:32]);
						compare("pipe_color_c_o", color_c, exp_word[31:16]);
						compare("pipe_color_d_o", color_d, exp_word[15:0]);
						received++;
					end
				end
				hold_q = pipe_stb && !pipe_ack;
				held_out = {pipe_dadr, pipe_x_frac, pipe_y_frac,
					color_a, color_b, color_c, color_d};
				seed = xorshift(seed);
				pipe_ack <= seed[1:0] != 2'b00; // Stalls a quarter of cycles.

				// Memory responder.
				if (mem_stb && mem_ack) begin
					mem_reads++;
					if (exp_line_q.size() == 0)
						abort_run("memory read with no miss outstanding");
					else
						compare("mem_adr_o", mem_adr, exp_line_q.pop_front());
					mem_ack <= 1'b0;
					seed = xorshift(seed);
					mem_wait = seed[1:0];
				end else if (mem_stb && !mem_ack) begin
					if (mem_wait == 0) begin
						mem_ack <= 1'b1;
						mem_dat <= line_mix(mem_adr);
					end else begin
						mem_wait--;
					end
				end
			end
		end
	end

	// ########################################################################
	// Reset and end of run
	// ########################################################################

	initial begin
		sys_rst = 1'b1;
		frag_stb = 1'b0;
		tadr_a = '0;
		tadr_b = '0;
		tadr_c = '0;
		tadr_d = '0;
		dadr = '0;
		x_frac = '0;
		y_frac = '0;
		pipe_ack = 1'b0;
		mem_ack = 1'b0;
		mem_dat = '0;
		seed = 32'h3bec;
		mdl_valid = '0;
		cycle = 0;
		sent = 0;
		received = 0;
		mem_reads = 0;
		exp_reads = 0;
		mem_wait = 0;
		running = 1'b0;
		hold_q = 1'b0;
		repeat (8) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);
		compare("pipe_stb_o", pipe_stb, 1'b0);
		compare("mem_stb_o", mem_stb, 1'b0);
		compare("busy_o", busy, 1'b0);
		running <= 1'b1;

		wait (received == NUM_FRAGS);
		@(posedge sys_clk);
		while (busy)
			@(posedge sys_clk);
		repeat (16) begin
			@(posedge sys_clk);
			compare("mem_stb_o", mem_stb, 1'b0); // Nothing left to fetch.
			compare("busy_o", busy, 1'b0);
		end
		compare("memory read count", mem_reads, exp_reads);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== design/texcache_top.sv ====
// Latency varies per fragment; results leave strictly in input order on pipe_stb_o.
`timescale 1ns/1ps

module texcache_top (
	input logic sys_clk,
	input logic sys_rst,

	input logic frag_stb_i,
	output logic frag_ack_o,
	input texcache_types_pkg::texel_adr_u frag_tadr_a_i,
	input texcache_types_pkg::texel_adr_u frag_tadr_b_i,
	input texcache_types_pkg::texel_adr_u frag_tadr_c_i,
	input texcache_types_pkg::texel_adr_u frag_tadr_d_i,
	input logic [texcache_cfg_pkg::DST_ADR_W-1:0] frag_dadr_i,
	input logic [texcache_cfg_pkg::FRAC_W-1:0] frag_x_frac_i,
	input logic [texcache_cfg_pkg::FRAC_W-1:0] frag_y_frac_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output logic [texcache_cfg_pkg::DST_ADR_W-1:0] pipe_dadr_o,
	output texcache_types_pkg::texel_t pipe_color_a_o,
	output texcache_types_pkg::texel_t pipe_color_b_o,
	output texcache_types_pkg::texel_t pipe_color_c_o,
	output texcache_types_pkg::texel_t pipe_color_d_o,
	output logic [texcache_cfg_pkg::FRAC_W-1:0] pipe_x_frac_o,
	output logic [texcache_cfg_pkg::FRAC_W-1:0] pipe_y_frac_o,

	output logic mem_stb_o,
	input logic mem_ack_i,
	output texcache_types_pkg::line_adr_t mem_adr_o,
	input texcache_types_pkg::line_t mem_dat_i,

	output logic busy_o
);
	import texcache_cfg_pkg::*;
	import texcache_types_pkg::*;

	logic tf_stb, tf_ack, req_stb, req_room, fetch_stb, fetch_ack;
	logic busy_tag, busy_fetch, busy_data;
	cache_adr_t tf_cadr_a, tf_cadr_b, tf_cadr_c, tf_cadr_d;
	logic [3:0] tf_miss, req_mask;
	logic [DST_ADR_W-1:0] tf_dadr;
	logic [FRAC_W-1:0] tf_x_frac, tf_y_frac;
	line_adr_t req_ladr_a, req_ladr_b, req_ladr_c, req_ladr_d;
	line_t fetch_dat;

	texcache_tagmem tagmem (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.frag_stb_i(frag_stb_i), .frag_ack_o(frag_ack_o),
		.frag_tadr_a_i(frag_tadr_a_i), .frag_tadr_b_i(frag_tadr_b_i),
		.frag_tadr_c_i(frag_tadr_c_i), .frag_tadr_d_i(frag_tadr_d_i),
		.frag_dadr_i(frag_dadr_i),
		.frag_x_frac_i(frag_x_frac_i), .frag_y_frac_i(frag_y_frac_i),
		.out_stb_o(tf_stb), .out_ack_i(tf_ack),
		.out_cadr_a_o(tf_cadr_a), .out_cadr_b_o(tf_cadr_b),
		.out_cadr_c_o(tf_cadr_c), .out_cadr_d_o(tf_cadr_d),
		.out_miss_o(tf_miss), .out_dadr_o(tf_dadr),
		.out_x_frac_o(tf_x_frac), .out_y_frac_o(tf_y_frac),
		.req_stb_o(req_stb), .req_room_i(req_room), .req_mask_o(req_mask),
		.req_ladr_a_o(req_ladr_a), .req_ladr_b_o(req_ladr_b),
		.req_ladr_c_o(req_ladr_c), .req_ladr_d_o(req_ladr_d),
		.busy_o(busy_tag)
	);

	texcache_fetch fetch (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.req_stb_i(req_stb), .req_room_o(req_room), .req_mask_i(req_mask),
		.req_ladr_a_i(req_ladr_a), .req_ladr_b_i(req_ladr_b),
		.req_ladr_c_i(req_ladr_c), .req_ladr_d_i(req_ladr_d),
		.mem_stb_o(mem_stb_o), .mem_ack_i(mem_ack_i),
		.mem_adr_o(mem_adr_o), .mem_dat_i(mem_dat_i),
		.fetch_stb_o(fetch_stb), .fetch_ack_i(fetch_ack), .fetch_dat_o(fetch_dat),
		.busy_o(busy_fetch)
	);

	texcache_datamem datamem (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.frag_stb_i(tf_stb), .frag_ack_o(tf_ack),
		.frag_cadr_a_i(tf_cadr_a), .frag_cadr_b_i(tf_cadr_b),
		.frag_cadr_c_i(tf_cadr_c), .frag_cadr_d_i(tf_cadr_d),
		.frag_miss_i(tf_miss), .frag_dadr_i(tf_dadr),
		.frag_x_frac_i(tf_x_frac), .frag_y_frac_i(tf_y_frac),
		.fetch_stb_i(fetch_stb), .fetch_ack_o(fetch_ack), .fetch_dat_i(fetch_dat),
		.pipe_stb_o(pipe_stb_o), .pipe_ack_i(pipe_ack_i), .pipe_dadr_o(pipe_dadr_o),
		.pipe_color_a_o(pipe_color_a_o), .pipe_color_b_o(pipe_color_b_o),
		.pipe_color_c_o(pipe_color_c_o), .pipe_color_d_o(pipe_color_d_o),
		.pipe_x_frac_o(pipe_x_frac_o), .pipe_y_frac_o(pipe_y_frac_o),
		.busy_o(busy_data)
	);

	assign busy_o = busy_tag || busy_fetch || busy_data; // Any block holding work.

endmodule

// ==== texcache/texcache_datamem.sv ====
// Lines must arrive in miss order a to d across fragments; colours come straight from the RAM.
`timescale 1ns/1ps

module texcache_datamem (
	input logic sys_clk,
	input logic sys_rst,

	input logic frag_stb_i,
	output logic frag_ack_o,
	input texcache_types_pkg::cache_adr_t frag_cadr_a_i,
	input texcache_types_pkg::cache_adr_t frag_cadr_b_i,
	input texcache_types_pkg::cache_adr_t frag_cadr_c_i,
	input texcache_types_pkg::cache_adr_t frag_cadr_d_i,
	input logic [3:0] frag_miss_i,
	input logic [texcache_cfg_pkg::DST_ADR_W-1:0] frag_dadr_i,
	input logic [texcache_cfg_pkg::FRAC_W-1:0] frag_x_frac_i,
	input logic [texcache_cfg_pkg::FRAC_W-1:0] frag_y_frac_i,

	input logic fetch_stb_i,
	output logic fetch_ack_o,
	input texcache_types_pkg::line_t fetch_dat_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output logic [texcache_cfg_pkg::DST_ADR_W-1:0] pipe_dadr_o,
	output texcache_types_pkg::texel_t pipe_color_a_o,
	output texcache_types_pkg::texel_t pipe_color_b_o,
	output texcache_types_pkg::texel_t pipe_color_c_o,
	output texcache_types_pkg::texel_t pipe_color_d_o,
	output logic [texcache_cfg_pkg::FRAC_W-1:0] pipe_x_frac_o,
	output logic [texcache_cfg_pkg::FRAC_W-1:0] pipe_y_frac_o,

	output logic busy_o
);
	import texcache_cfg_pkg::*;
	import texcache_types_pkg::*;

	typedef enum logic [1:0] {S_RUNNING, S_COMMIT, S_STROBE} state_t;

	state_t state_q, state_d;
	logic req_ce, req_valid_q, retry;
	cache_adr_t cadr_in [4];
	cache_adr_t cadr_q [4];
	cache_adr_t rd_adr [4];
	logic [3:0] miss_q, missmask_q, pending;
	logic missmask_init, missmask_we, we;
	logic [1:0] wa_sel;

	assign cadr_in[0] = frag_cadr_a_i;
	assign cadr_in[1] = frag_cadr_b_i;
	assign cadr_in[2] = frag_cadr_c_i;
	assign cadr_in[3] = frag_cadr_d_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			req_valid_q <= 1'b0;
		else if (req_ce)
			req_valid_q <= frag_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (req_ce) begin
			cadr_q <= cadr_in;
			miss_q <= frag_miss_i;
			pipe_dadr_o <= frag_dadr_i;
			pipe_x_frac_o <= frag_x_frac_i;
			pipe_y_frac_o <= frag_y_frac_i;
		end
	end

	// Reread the held fragment while it waits or commits.
	always_comb begin
		for (int i = 0; i < 4; i++)
			rd_adr[i] = retry ? cadr_q[i] : cadr_in[i];
	end

	// ########################################################################
	// Line commit
	// ########################################################################

	assign pending = miss_q & missmask_q;

	always_comb begin
		if (pending[0])
			wa_sel = 2'd0;
		else if (pending[1])
			wa_sel = 2'd1; // Texel b owns its own slot.
		else if (pending[2])
			wa_sel = 2'd2;
		else
			wa_sel = 2'd3;
	end

	always_ff @(posedge sys_clk) begin
		if (missmask_init)
			missmask_q <= 4'b1111;
		else if (missmask_we)
			missmask_q <= missmask_q & ~(4'b0001 << wa_sel);
	end

	texcache_qpram qpram (
		.sys_clk(sys_clk),
		.rd_adr_a_i(rd_adr[0]),
		.rd_adr_b_i(rd_adr[1]),
		.rd_adr_c_i(rd_adr[2]),
		.rd_adr_d_i(rd_adr[3]),
		.rd_dat_a_o(pipe_color_a_o),
		.rd_dat_b_o(pipe_color_b_o),
		.rd_dat_c_o(pipe_color_c_o),
		.rd_dat_d_o(pipe_color_d_o),
		.wr_en_i(we),
		.wr_index_i(cadr_q[wa_sel][CACHE_ADR_W-1:OFFSET_W]),
		.wr_line_i(fetch_dat_i)
	);

	// ########################################################################
	// Control
	// ########################################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state_q <= S_RUNNING;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		frag_ack_o = 1'b0;
		fetch_ack_o = 1'b0;
		pipe_stb_o = 1'b0;
		req_ce = 1'b0;
		retry = 1'b0;
		we = 1'b0;
		missmask_init = 1'b0;
		missmask_we = 1'b0;
		case (state_q)
			S_RUNNING: begin
				missmask_init = 1'b1;
				if (!req_valid_q || (miss_q == '0 && pipe_ack_i)) begin
					pipe_stb_o = req_valid_q;
					frag_ack_o = 1'b1;
					req_ce = 1'b1;
				end else if (miss_q != '0) begin
					retry = 1'b1;
					state_d = S_COMMIT;
				end else begin
					pipe_stb_o = 1'b1; // Stalled downstream.
					retry = 1'b1;
				end
			end
			S_COMMIT: begin
				retry = 1'b1;
				if (pending == '0) begin
					state_d = S_STROBE; // Last write landed, reread now.
				end else begin
					fetch_ack_o = 1'b1;
					if (fetch_stb_i) begin
						we = 1'b1;
						missmask_we = 1'b1;
					end
				end
			end
			default: begin
				pipe_stb_o = 1'b1;
				retry = !pipe_ack_i;
				if (pipe_ack_i) begin
					frag_ack_o = 1'b1;
					req_ce = 1'b1;
					state_d = S_RUNNING;
				end
			end
		endcase
	end

	assign busy_o = req_valid_q || state_q != S_RUNNING;

	a_pipe_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o && $stable({pipe_color_a_o,
		pipe_color_b_o, pipe_color_c_o, pipe_color_d_o}));

endmodule

// ==== texcache/texcache_fetch.sv ====
// One memory read outstanding; a push needs four free slots whatever its mask.
`timescale 1ns/1ps

module texcache_fetch (
	input logic sys_clk,
	input logic sys_rst,

	input logic req_stb_i,
	output logic req_room_o,
	input logic [3:0] req_mask_i,
	input texcache_types_pkg::line_adr_t req_ladr_a_i,
	input texcache_types_pkg::line_adr_t req_ladr_b_i,
	input texcache_types_pkg::line_adr_t req_ladr_c_i,
	input texcache_types_pkg::line_adr_t req_ladr_d_i,

	output logic mem_stb_o,
	input logic mem_ack_i,
	output texcache_types_pkg::line_adr_t mem_adr_o,
	input texcache_types_pkg::line_t mem_dat_i,

	output logic fetch_stb_o,
	input logic fetch_ack_i,
	output texcache_types_pkg::line_t fetch_dat_o,

	output logic busy_o
);
	import texcache_cfg_pkg::*;
	import texcache_types_pkg::*;

	typedef logic [$clog2(FETCH_FIFO_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(FETCH_FIFO_DEPTH):0] cnt_t;
	typedef enum logic [1:0] {F_IDLE, F_MEM, F_HAND} fstate_t;

	line_adr_t fifo_q [FETCH_FIFO_DEPTH];
	line_adr_t ladr [4];
	ptr_t wr_ptr_q, rd_ptr_q;
	ptr_t wr_slot [4];
	cnt_t count_q, push_cnt;
	fstate_t state_q;
	logic push, pop;

	assign ladr[0] = req_ladr_a_i;
	assign ladr[1] = req_ladr_b_i;
	assign ladr[2] = req_ladr_c_i;
	assign ladr[3] = req_ladr_d_i;

	// Masked addresses pack into consecutive slots, a first.
	always_comb begin
		push_cnt = '0;
		for (int i = 0; i < 4; i++) begin
			wr_slot[i] = wr_ptr_q + ptr_t'(push_cnt);
			if (req_mask_i[i])
				push_cnt = push_cnt + 1'b1;
		end
	end

	assign req_room_o = count_q <= cnt_t'(FETCH_FIFO_DEPTH - 4);
	assign push = req_stb_i && req_room_o;
	assign pop = fetch_stb_o && fetch_ack_i;

	always_ff @(posedge sys_clk) begin
		if (push) begin
			for (int i = 0; i < 4; i++) begin
				if (req_mask_i[i])
					fifo_q[wr_slot[i]] <= ladr[i];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + ptr_t'(push_cnt);
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + (push ? push_cnt : cnt_t'(0)) - cnt_t'(pop);
		end
	end

	// ########################################################################
	// Read sequencer
	// ########################################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= F_IDLE;
		end else begin
			case (state_q)
				F_IDLE: if (count_q != '0) state_q <= F_MEM;
				F_MEM: if (mem_ack_i) state_q <= F_HAND;
				default: if (fetch_ack_i) state_q <= F_IDLE; // Head popped here.
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (mem_stb_o && mem_ack_i)
			fetch_dat_o <= mem_dat_i;
	end

	assign mem_adr_o = fifo_q[rd_ptr_q]; // Head stays put until the pop.
	assign mem_stb_o = state_q == F_MEM;
	assign fetch_stb_o = state_q == F_HAND;
	assign busy_o = state_q != F_IDLE || count_q != '0;

	// Free space seen by the pointers must agree with the count that grants room.
	a_push_fits: assert property (@(posedge sys_clk) disable iff (sys_rst)
		push |-> ptr_t'(wr_ptr_q - rd_ptr_q) == ptr_t'(count_q) &&
		count_q + push_cnt <= cnt_t'(FETCH_FIFO_DEPTH));

	a_adr_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_stb_o && !mem_ack_i |=> mem_stb_o && $stable(mem_adr_o));

endmodule

// ==== texcache/texcache_tagmem.sv ====
// Texels of one fragment on the same line index must share a tag; invalidation only by reset.
`timescale 1ns/1ps

module texcache_tagmem (
	input logic sys_clk,
	input logic sys_rst,

	input logic frag_stb_i,
	output logic frag_ack_o,
	input texcache_types_pkg::texel_adr_u frag_tadr_a_i,
	input texcache_types_pkg::texel_adr_u frag_tadr_b_i,
	input texcache_types_pkg::texel_adr_u frag_tadr_c_i,
	input texcache_types_pkg::texel_adr_u frag_tadr_d_i,
	input logic [texcache_cfg_pkg::DST_ADR_W-1:0] frag_dadr_i,
	input logic [texcache_cfg_pkg::FRAC_W-1:0] frag_x_frac_i,
	input logic [texcache_cfg_pkg::FRAC_W-1:0] frag_y_frac_i,

	output logic out_stb_o,
	input logic out_ack_i,
	output texcache_types_pkg::cache_adr_t out_cadr_a_o,
	output texcache_types_pkg::cache_adr_t out_cadr_b_o,
	output texcache_types_pkg::cache_adr_t out_cadr_c_o,
	output texcache_types_pkg::cache_adr_t out_cadr_d_o,
	output logic [3:0] out_miss_o,
	output logic [texcache_cfg_pkg::DST_ADR_W-1:0] out_dadr_o,
	output logic [texcache_cfg_pkg::FRAC_W-1:0] out_x_frac_o,
	output logic [texcache_cfg_pkg::FRAC_W-1:0] out_y_frac_o,

	output logic req_stb_o,
	input logic req_room_i,
	output logic [3:0] req_mask_o,
	output texcache_types_pkg::line_adr_t req_ladr_a_o,
	output texcache_types_pkg::line_adr_t req_ladr_b_o,
	output texcache_types_pkg::line_adr_t req_ladr_c_o,
	output texcache_types_pkg::line_adr_t req_ladr_d_o,

	output logic busy_o
);
	import texcache_cfg_pkg::*;
	import texcache_types_pkg::*;

	logic [2**INDEX_W-1:0] valid_q;
	logic [TAG_W-1:0] tag_q [2**INDEX_W];

	texel_adr_u tadr [4];
	logic [3:0] miss;
	logic out_free;
	logic accept;

	assign tadr[0] = frag_tadr_a_i;
	assign tadr[1] = frag_tadr_b_i;
	assign tadr[2] = frag_tadr_c_i;
	assign tadr[3] = frag_tadr_d_i;

	// Lookup, then merge repeated lines so only the first one fetches.
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			miss[i] = !(valid_q[tadr[i].fld.index] &&
				tag_q[tadr[i].fld.index] == tadr[i].fld.tag);
			for (int j = 0; j < i; j++) begin
				if (tadr[j].fld.index == tadr[i].fld.index && tadr[j].fld.tag == tadr[i].fld.tag)
					miss[i] = 1'b0;
			end
		end
	end

	assign out_free = !out_stb_o || out_ack_i;
	assign frag_ack_o = out_free && req_room_i;
	assign accept = frag_stb_i && frag_ack_o;

	assign req_stb_o = frag_stb_i && out_free && (|miss); // Pushed with the fragment.
	assign req_mask_o = miss;
	assign req_ladr_a_o = {tadr[0].fld.tag, tadr[0].fld.index};
	assign req_ladr_b_o = {tadr[1].fld.tag, tadr[1].fld.index};
	assign req_ladr_c_o = {tadr[2].fld.tag, tadr[2].fld.index};
	assign req_ladr_d_o = {tadr[3].fld.tag, tadr[3].fld.index};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_q <= '0;
		end else if (accept) begin
			for (int i = 0; i < 4; i++) begin
				if (miss[i])
					valid_q[tadr[i].fld.index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			for (int i = 0; i < 4; i++) begin
				if (miss[i])
					tag_q[tadr[i].fld.index] <= tadr[i].fld.tag; // Line now owned.
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			out_stb_o <= 1'b0;
		else if (accept)
			out_stb_o <= 1'b1;
		else if (out_ack_i)
			out_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			out_cadr_a_o <= {tadr[0].fld.index, tadr[0].fld.offset};
			out_cadr_b_o <= {tadr[1].fld.index, tadr[1].fld.offset};
			out_cadr_c_o <= {tadr[2].fld.index, tadr[2].fld.offset};
			out_cadr_d_o <= {tadr[3].fld.index, tadr[3].fld.offset};
			out_miss_o <= miss;
			out_dadr_o <= frag_dadr_i;
			out_x_frac_o <= frag_x_frac_i;
			out_y_frac_o <= frag_y_frac_i;
		end
	end

	assign busy_o = out_stb_o;

	a_out_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_stb_o && !out_ack_i |=> out_stb_o && $stable({out_cadr_a_o, out_cadr_b_o,
		out_cadr_c_o, out_cadr_d_o, out_miss_o, out_dadr_o, out_x_frac_o, out_y_frac_o}));

endmodule

// ==== texcache/texcache_qpram.sv ====
// Reads return the old line when a write hits the same index in the same cycle.
`timescale 1ns/1ps

module texcache_qpram (
	input logic sys_clk,

	input texcache_types_pkg::cache_adr_t rd_adr_a_i,
	input texcache_types_pkg::cache_adr_t rd_adr_b_i,
	input texcache_types_pkg::cache_adr_t rd_adr_c_i,
	input texcache_types_pkg::cache_adr_t rd_adr_d_i,
	output texcache_types_pkg::texel_t rd_dat_a_o,
	output texcache_types_pkg::texel_t rd_dat_b_o,
	output texcache_types_pkg::texel_t rd_dat_c_o,
	output texcache_types_pkg::texel_t rd_dat_d_o,

	input logic wr_en_i,
	input logic [texcache_cfg_pkg::INDEX_W-1:0] wr_index_i,
	input texcache_types_pkg::line_t wr_line_i
);
	import texcache_cfg_pkg::*;
	import texcache_types_pkg::*;

	line_t mem [2**INDEX_W];

	always_ff @(posedge sys_clk) begin
		if (wr_en_i)
			mem[wr_index_i] <= wr_line_i; // Whole line per beat.
	end

	always_ff @(posedge sys_clk) begin
		rd_dat_a_o <= mem[rd_adr_a_i[CACHE_ADR_W-1:OFFSET_W]][rd_adr_a_i[OFFSET_W-1:0]];
		rd_dat_b_o <= mem[rd_adr_b_i[CACHE_ADR_W-1:OFFSET_W]][rd_adr_b_i[OFFSET_W-1:0]];
		rd_dat_c_o <= mem[rd_adr_c_i[CACHE_ADR_W-1:OFFSET_W]][rd_adr_c_i[OFFSET_W-1:0]];
		rd_dat_d_o <= mem[rd_adr_d_i[CACHE_ADR_W-1:OFFSET_W]][rd_adr_d_i[OFFSET_W-1:0]];
	end

endmodule

// ==== common/texcache_types_pkg.sv ====
// Texel colours are 16 bits; both views of texel_adr_u cover the same 24-bit word.
package texcache_types_pkg;

	typedef logic [texcache_cfg_pkg::LINE_W/texcache_cfg_pkg::LINE_TEXELS-1:0] texel_t;

	// Texel at offset k sits at bits 16k upward.
	typedef texel_t [texcache_cfg_pkg::LINE_TEXELS-1:0] line_t;

	typedef struct packed {
		logic [texcache_cfg_pkg::TAG_W-1:0] tag;
		logic [texcache_cfg_pkg::INDEX_W-1:0] index;
		logic [texcache_cfg_pkg::OFFSET_W-1:0] offset;
	} texel_fields_t;

	// Raw memory address, or the cache split of the same bits.
	typedef union packed {
		logic [texcache_cfg_pkg::TEX_ADR_W-1:0] raw;
		texel_fields_t fld;
	} texel_adr_u;

	typedef logic [texcache_cfg_pkg::CACHE_ADR_W-1:0] cache_adr_t; // Index and offset.
	typedef logic [texcache_cfg_pkg::LINE_ADR_W-1:0] line_adr_t; // Tag and index.

endpackage

// ==== common/texcache_cfg_pkg.sv ====
// Fixed cache geometry; a texel address must split exactly into tag, index and offset.
package texcache_cfg_pkg;

	// ########################################################################
	// Address widths
	// ########################################################################

	localparam int TEX_ADR_W = 24; // Texel words in texture memory.
	localparam int DST_ADR_W = 24; // Destination words.
	localparam int FRAC_W = 6; // Bilinear weight bits.

	// ########################################################################
	// Direct-mapped cache
	// ########################################################################

	localparam int LINE_TEXELS = 16;
	localparam int OFFSET_W = 4; // Log2 of LINE_TEXELS.
	localparam int INDEX_W = 8; // 256 lines.
	localparam int TAG_W = TEX_ADR_W - INDEX_W - OFFSET_W;

	localparam int CACHE_ADR_W = INDEX_W + OFFSET_W;
	localparam int LINE_ADR_W = TAG_W + INDEX_W;
	localparam int LINE_W = LINE_TEXELS * 16; // One memory beat.

	// Room for one full fragment of requests is needed to push.
	localparam int FETCH_FIFO_DEPTH = 8;

endpackage
